/* ahb_pkg.sv */
// AHB-Lite transfer encodings and bus width constants

package ahb_pkg;

  localparam int unsigned AhbDataWidth = 64;
  localparam int unsigned AhbStrbWidth = AhbDataWidth / 8;

  // hsize code of a 32-bit access
  localparam logic [2:0] HsizeWord = 3'b010;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

endpackage

/* i3c_csr_pkg.sv */
// CSR port widths, register offsets and field positions of the I3C host block

package i3c_csr_pkg;

  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned CsrAddrWidth = 5;

  typedef enum logic [CsrAddrWidth-1:0] {
    HC_CONTROL      = 5'h00,
    RESET_CONTROL   = 5'h04,
    QUEUE_THLD_CTRL = 5'h08,
    INTR_STATUS     = 5'h0C,
    INTR_ENABLE     = 5'h10,
    QUEUE_SIZE      = 5'h14,
    COMMAND_PORT    = 5'h18,
    RX_DATA_PORT    = 5'h1C
  } csr_offset_e;

  // HC_CONTROL
  localparam int unsigned BusEnableBit = 0;

  // RESET_CONTROL
  localparam int unsigned CmdQueueRstBit = 0;
  localparam int unsigned RxQueueRstBit  = 1;

  // Threshold and queue size fields are all one byte wide
  localparam int unsigned QueueFieldWidth = 8;

  // QUEUE_THLD_CTRL
  localparam int unsigned CmdEmptyBufThldLsb = 0;
  localparam int unsigned RxBufThldLsb       = 8;

  // INTR_STATUS and INTR_ENABLE
  localparam int unsigned CmdReadyStatBit = 0;
  localparam int unsigned RxThldStatBit   = 1;

  // QUEUE_SIZE
  localparam int unsigned QsizeCmdLsb = 0;
  localparam int unsigned QsizeRxLsb  = 8;

endpackage

/* i3c_queue.sv */
// Show-ahead FIFO with flush, occupancy count and full/empty flags

module i3c_queue #(
  parameter int unsigned Width      = 32,
  parameter int unsigned QueueDepth = 8
) (
  input  logic                        hclk_i,
  input  logic                        arst_n_i,
  input  logic                        flush_i,
  input  logic                        push_i,
  input  logic [Width-1:0]            data_i,
  input  logic                        pop_i,
  output logic [Width-1:0]            data_o,
  output logic                        empty_o,
  output logic                        full_o,
  output logic [$clog2(QueueDepth):0] count_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);
  localparam int unsigned CntWidth = PtrWidth + 1;

  logic [Width-1:0]    mem [QueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CntWidth'(do_push) - CntWidth'(do_pop);
    end
  end

  always_ff @(posedge hclk_i) begin
    if (do_push && !flush_i) mem[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem[rd_ptr_q];
  assign count_o = count_q;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(QueueDepth));

  // Producer and consumer must respect the flags
  a_no_push_full: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    push_i && !flush_i |-> !full_o)
    else $error("push into full queue");

  a_no_pop_empty: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    pop_i && !flush_i |-> !empty_o)
    else $error("pop from empty queue");

endmodule

/* ahb_csr_bridge.sv */
// AHB-Lite slave that turns single transfers into CSR requests
// Adds one wait state per access and the two-cycle ERROR response

module ahb_csr_bridge #(
  parameter int unsigned AhbAddrWidth = 32
) (
  input  logic                                 hclk_i,
  input  logic                                 arst_n_i,
  input  logic [AhbAddrWidth-1:0]              haddr_i,
  input  logic [2:0]                           hburst_i,
  input  logic [3:0]                           hprot_i,
  input  logic [2:0]                           hsize_i,
  input  logic [1:0]                           htrans_i,
  input  logic [ahb_pkg::AhbDataWidth-1:0]     hwdata_i,
  input  logic [ahb_pkg::AhbStrbWidth-1:0]     hwstrb_i,
  input  logic                                 hwrite_i,
  input  logic                                 hsel_i,
  input  logic                                 hready_i,
  output logic [ahb_pkg::AhbDataWidth-1:0]     hrdata_o,
  output logic                                 hreadyout_o,
  output logic                                 hresp_o,
  output logic                                 csr_req_o,
  output logic                                 csr_req_is_wr_o,
  output logic [i3c_csr_pkg::CsrAddrWidth-1:0] csr_addr_o,
  output logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_wr_data_o,
  output logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_wr_biten_o,
  input  logic                                 csr_rd_ack_i,
  input  logic                                 csr_rd_err_i,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_rd_data_i,
  input  logic                                 csr_wr_ack_i,
  input  logic                                 csr_wr_err_i
);

  import ahb_pkg::*;
  import i3c_csr_pkg::*;

  localparam int unsigned LaneBytes = CsrDataWidth / 8;

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_REQ,
    BR_WAIT_ACK,
    BR_ERR1,
    BR_ERR2
  } bridge_state_e;

  bridge_state_e           state_q;
  bridge_state_e           state_d;
  logic                    take;
  logic                    ack_err;
  logic                    lane_q;
  logic                    is_wr_q;
  logic                    size_err_q;
  logic [CsrAddrWidth-1:0] addr_q;
  logic [LaneBytes-1:0]    lane_strb;

  // New address phase, only while the previous data phase completes
  assign take = hsel_i && hready_i && hreadyout_o && (htrans_i == NONSEQ || htrans_i == SEQ);

  assign ack_err = (csr_rd_ack_i && csr_rd_err_i) || (csr_wr_ack_i && csr_wr_err_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: begin
        if (take) state_d = BR_REQ;
      end
      BR_REQ: begin
        state_d = size_err_q ? BR_ERR1 : BR_WAIT_ACK;
      end
      BR_WAIT_ACK: begin
        if (ack_err) state_d = BR_ERR2;
        else if (take) state_d = BR_REQ;
        else state_d = BR_IDLE;
      end
      BR_ERR1: begin
        state_d = BR_ERR2;
      end
      BR_ERR2: begin
        state_d = take ? BR_REQ : BR_IDLE;
      end
      default: begin
        state_d = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address phase capture, word aligned within the block
  always_ff @(posedge hclk_i) begin
    if (take) begin
      addr_q     <= {haddr_i[CsrAddrWidth-1:2], 2'b00};
      lane_q     <= haddr_i[2];
      is_wr_q    <= hwrite_i;
      size_err_q <= (hsize_i > HsizeWord);
    end
  end

  assign csr_req_o       = (state_q == BR_REQ) && !size_err_q;
  assign csr_req_is_wr_o = is_wr_q;
  assign csr_addr_o      = addr_q;
  assign csr_wr_data_o   = hwdata_i[lane_q*CsrDataWidth +: CsrDataWidth];
  assign lane_strb       = hwstrb_i[lane_q*LaneBytes +: LaneBytes];

  always_comb begin
    for (int i = 0; i < LaneBytes; i++) begin
      csr_wr_biten_o[i*8 +: 8] = {8{lane_strb[i]}};
    end
  end

  always_comb begin
    hreadyout_o = 1'b1;
    hresp_o     = OKAY;
    case (state_q)
      BR_REQ: begin
        hreadyout_o = 1'b0;
      end
      BR_WAIT_ACK: begin
        if (ack_err) begin
          hreadyout_o = 1'b0;
          hresp_o     = ERROR;
        end
      end
      BR_ERR1: begin
        hreadyout_o = 1'b0;
        hresp_o     = ERROR;
      end
      BR_ERR2: begin
        hresp_o = ERROR;
      end
      default: begin
        hreadyout_o = 1'b1;
      end
    endcase
  end

  // Read data sits in the addressed lane, the other lane stays zero
  always_comb begin
    hrdata_o = '0;
    if (state_q == BR_WAIT_ACK && csr_rd_ack_i && !csr_rd_err_i) begin
      hrdata_o[lane_q*CsrDataWidth +: CsrDataWidth] = csr_rd_data_i;
    end
  end

  a_ack_after_req: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    csr_req_o |=> (csr_rd_ack_i != csr_wr_ack_i) && (csr_wr_ack_i == $past(csr_req_is_wr_o)))
    else $error("CSR request without a matching ack");

  a_no_stray_ack: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    (csr_rd_ack_i || csr_wr_ack_i) |-> $past(csr_req_o))
    else $error("CSR ack without a request");

  a_err_two_cycles: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    (hresp_o == ERROR && !hreadyout_o) |=> (hresp_o == ERROR && hreadyout_o))
    else $error("broken two-cycle ERROR response");

endmodule

/* i3c_csr_regs.sv */
// CSR register block of the I3C host
// Decodes requests, drives the queue strobes and the threshold interrupt

module i3c_csr_regs #(
  parameter int unsigned QueueDepth = 8
) (
  input  logic                                 hclk_i,
  input  logic                                 arst_n_i,
  input  logic                                 csr_req_i,
  input  logic                                 csr_req_is_wr_i,
  input  logic [i3c_csr_pkg::CsrAddrWidth-1:0] csr_addr_i,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_wr_data_i,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_wr_biten_i,
  output logic                                 csr_rd_ack_o,
  output logic                                 csr_rd_err_o,
  output logic [i3c_csr_pkg::CsrDataWidth-1:0] csr_rd_data_o,
  output logic                                 csr_wr_ack_o,
  output logic                                 csr_wr_err_o,
  output logic                                 cmd_push_o,
  output logic [i3c_csr_pkg::CsrDataWidth-1:0] cmd_push_data_o,
  output logic                                 cmd_flush_o,
  output logic                                 cmd_pop_o,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] cmd_head_i,
  input  logic                                 cmd_empty_i,
  input  logic                                 cmd_full_i,
  input  logic [$clog2(QueueDepth):0]          cmd_count_i,
  output logic                                 rx_pop_o,
  output logic                                 rx_flush_o,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] rx_head_i,
  input  logic                                 rx_empty_i,
  input  logic [$clog2(QueueDepth):0]          rx_count_i,
  input  logic                                 cmd_pop_i,
  output logic                                 cmd_valid_o,
  output logic                                 intr_o
);

  import i3c_csr_pkg::*;

  localparam int unsigned CntWidth = $clog2(QueueDepth) + 1;

  logic [CsrDataWidth-1:0]    hc_control_q;
  logic [CsrDataWidth-1:0]    thld_ctrl_q;
  logic [CsrDataWidth-1:0]    intr_enable_q;
  logic [CsrDataWidth-1:0]    wr_masked;
  logic [CsrDataWidth-1:0]    intr_status;
  logic [CsrDataWidth-1:0]    queue_size;
  logic [CsrDataWidth-1:0]    rd_data_d;
  logic [QueueFieldWidth-1:0] cmd_thld;
  logic [QueueFieldWidth-1:0] rx_thld;
  logic [CntWidth-1:0]        cmd_free;
  logic                       err_d;
  logic                       hc_we;
  logic                       thld_we;
  logic                       ien_we;
  logic                       intr_q;

  assign wr_masked = csr_wr_data_i & csr_wr_biten_i;
  assign cmd_thld  = thld_ctrl_q[CmdEmptyBufThldLsb +: QueueFieldWidth];
  assign rx_thld   = thld_ctrl_q[RxBufThldLsb +: QueueFieldWidth];
  assign cmd_free  = CntWidth'(QueueDepth) - cmd_count_i;

  always_comb begin
    intr_status = '0;
    intr_status[CmdReadyStatBit] = CsrDataWidth'(cmd_free) >= CsrDataWidth'(cmd_thld);
    intr_status[RxThldStatBit]   = (rx_count_i != '0) &&
                                   (CsrDataWidth'(rx_count_i) >= CsrDataWidth'(rx_thld));
    queue_size = '0;
    queue_size[QsizeCmdLsb +: QueueFieldWidth] = QueueFieldWidth'(cmd_count_i);
    queue_size[QsizeRxLsb +: QueueFieldWidth]  = QueueFieldWidth'(rx_count_i);
  end

  // Strobes fire in the request cycle so they land on the ack edge
  always_comb begin
    err_d       = 1'b0;
    rd_data_d   = '0;
    hc_we       = 1'b0;
    thld_we     = 1'b0;
    ien_we      = 1'b0;
    cmd_push_o  = 1'b0;
    cmd_flush_o = 1'b0;
    rx_pop_o    = 1'b0;
    rx_flush_o  = 1'b0;
    if (csr_req_i) begin
      case (csr_offset_e'(csr_addr_i))
        HC_CONTROL: begin
          hc_we     = csr_req_is_wr_i;
          rd_data_d = hc_control_q;
        end
        RESET_CONTROL: begin
          cmd_flush_o = csr_req_is_wr_i && wr_masked[CmdQueueRstBit];
          rx_flush_o  = csr_req_is_wr_i && wr_masked[RxQueueRstBit];
        end
        QUEUE_THLD_CTRL: begin
          thld_we   = csr_req_is_wr_i;
          rd_data_d = thld_ctrl_q;
        end
        INTR_STATUS: begin
          err_d     = csr_req_is_wr_i;
          rd_data_d = intr_status;
        end
        INTR_ENABLE: begin
          ien_we    = csr_req_is_wr_i;
          rd_data_d = intr_enable_q;
        end
        QUEUE_SIZE: begin
          err_d     = csr_req_is_wr_i;
          rd_data_d = queue_size;
        end
        COMMAND_PORT: begin
          err_d      = !csr_req_is_wr_i || cmd_full_i;
          cmd_push_o = csr_req_is_wr_i && !cmd_full_i;
        end
        RX_DATA_PORT: begin
          err_d    = csr_req_is_wr_i || rx_empty_i;
          rx_pop_o = !csr_req_is_wr_i && !rx_empty_i;
          if (rx_pop_o) rd_data_d = rx_head_i;
        end
        default: begin
          err_d = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge hclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hc_control_q  <= '0;
      thld_ctrl_q   <= '0;
      intr_enable_q <= '0;
      csr_rd_ack_o  <= 1'b0;
      csr_rd_err_o  <= 1'b0;
      csr_wr_ack_o  <= 1'b0;
      csr_wr_err_o  <= 1'b0;
      intr_q        <= 1'b0;
    end else begin
      csr_rd_ack_o <= csr_req_i && !csr_req_is_wr_i;
      csr_rd_err_o <= csr_req_i && !csr_req_is_wr_i && err_d;
      csr_wr_ack_o <= csr_req_i && csr_req_is_wr_i;
      csr_wr_err_o <= csr_req_i && csr_req_is_wr_i && err_d;
      if (hc_we) hc_control_q <= (hc_control_q & ~csr_wr_biten_i) | wr_masked;
      if (thld_we) thld_ctrl_q <= (thld_ctrl_q & ~csr_wr_biten_i) | wr_masked;
      if (ien_we) intr_enable_q <= (intr_enable_q & ~csr_wr_biten_i) | wr_masked;
      intr_q <= |(intr_status & intr_enable_q);
    end
  end

  always_ff @(posedge hclk_i) begin
    csr_rd_data_o <= rd_data_d;
  end

  assign cmd_push_data_o = wr_masked;
  assign cmd_pop_o       = cmd_pop_i;
  assign cmd_valid_o     = !cmd_empty_i && hc_control_q[BusEnableBit];
  assign intr_o          = intr_q;

  // Core only pops what it has been offered
  a_pop_when_valid: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    cmd_pop_i |-> cmd_valid_o)
    else $error("core popped the command queue while cmd_valid_o was low");

  a_head_known: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
    cmd_valid_o |-> !$isunknown(cmd_head_i))
    else $error("offered command word is unknown");

endmodule

/* i3c_ahb_subsys.sv */
// Top level with the AHB-Lite bridge, the CSR block and both queues

module i3c_ahb_subsys #(
  parameter int unsigned AhbAddrWidth = 32,
  parameter int unsigned QueueDepth   = 8
) (
  input  logic                                 hclk_i,
  input  logic                                 arst_n_i,
  input  logic [AhbAddrWidth-1:0]              haddr_i,
  input  logic [2:0]                           hburst_i,
  input  logic [3:0]                           hprot_i,
  input  logic [2:0]                           hsize_i,
  input  logic [1:0]                           htrans_i,
  input  logic [ahb_pkg::AhbDataWidth-1:0]     hwdata_i,
  input  logic [ahb_pkg::AhbStrbWidth-1:0]     hwstrb_i,
  input  logic                                 hwrite_i,
  input  logic                                 hsel_i,
  input  logic                                 hready_i,
  output logic [ahb_pkg::AhbDataWidth-1:0]     hrdata_o,
  output logic                                 hreadyout_o,
  output logic                                 hresp_o,
  output logic                                 cmd_valid_o,
  output logic [i3c_csr_pkg::CsrDataWidth-1:0] cmd_data_o,
  input  logic                                 cmd_pop_i,
  input  logic                                 rx_push_i,
  input  logic [i3c_csr_pkg::CsrDataWidth-1:0] rx_data_i,
  output logic                                 rx_full_o,
  output logic                                 intr_o
);

  import i3c_csr_pkg::*;

  localparam int unsigned CntWidth = $clog2(QueueDepth) + 1;

  logic                    csr_req;
  logic                    csr_req_is_wr;
  logic [CsrAddrWidth-1:0] csr_addr;
  logic [CsrDataWidth-1:0] csr_wr_data;
  logic [CsrDataWidth-1:0] csr_wr_biten;
  logic                    csr_rd_ack;
  logic                    csr_rd_err;
  logic [CsrDataWidth-1:0] csr_rd_data;
  logic                    csr_wr_ack;
  logic                    csr_wr_err;
  logic                    cmd_push;
  logic [CsrDataWidth-1:0] cmd_push_data;
  logic                    cmd_flush;
  logic                    cmd_pop;
  logic                    cmd_empty;
  logic                    cmd_full;
  logic [CntWidth-1:0]     cmd_count;
  logic                    rx_pop;
  logic                    rx_flush;
  logic [CsrDataWidth-1:0] rx_head;
  logic                    rx_empty;
  logic [CntWidth-1:0]     rx_count;

  ahb_csr_bridge #(
    .AhbAddrWidth(AhbAddrWidth)
  ) u_bridge (
    .hclk_i, .arst_n_i, .haddr_i, .hburst_i, .hprot_i, .hsize_i, .htrans_i,
    .hwdata_i, .hwstrb_i, .hwrite_i, .hsel_i, .hready_i,
    .hrdata_o, .hreadyout_o, .hresp_o,
    .csr_req_o(csr_req), .csr_req_is_wr_o(csr_req_is_wr), .csr_addr_o(csr_addr),
    .csr_wr_data_o(csr_wr_data), .csr_wr_biten_o(csr_wr_biten),
    .csr_rd_ack_i(csr_rd_ack), .csr_rd_err_i(csr_rd_err), .csr_rd_data_i(csr_rd_data),
    .csr_wr_ack_i(csr_wr_ack), .csr_wr_err_i(csr_wr_err)
  );

  i3c_csr_regs #(
    .QueueDepth(QueueDepth)
  ) u_regs (
    .hclk_i, .arst_n_i,
    .csr_req_i(csr_req), .csr_req_is_wr_i(csr_req_is_wr), .csr_addr_i(csr_addr),
    .csr_wr_data_i(csr_wr_data), .csr_wr_biten_i(csr_wr_biten),
    .csr_rd_ack_o(csr_rd_ack), .csr_rd_err_o(csr_rd_err), .csr_rd_data_o(csr_rd_data),
    .csr_wr_ack_o(csr_wr_ack), .csr_wr_err_o(csr_wr_err),
    .cmd_push_o(cmd_push), .cmd_push_data_o(cmd_push_data), .cmd_flush_o(cmd_flush),
    .cmd_pop_o(cmd_pop), .cmd_head_i(cmd_data_o), .cmd_empty_i(cmd_empty),
    .cmd_full_i(cmd_full), .cmd_count_i(cmd_count),
    .rx_pop_o(rx_pop), .rx_flush_o(rx_flush), .rx_head_i(rx_head),
    .rx_empty_i(rx_empty), .rx_count_i(rx_count),
    .cmd_pop_i, .cmd_valid_o, .intr_o
  );

  i3c_queue #(
    .Width     (CsrDataWidth),
    .QueueDepth(QueueDepth)
  ) u_cmd_queue (
    .hclk_i, .arst_n_i,
    .flush_i(cmd_flush), .push_i(cmd_push), .data_i(cmd_push_data), .pop_i(cmd_pop),
    .data_o(cmd_data_o), .empty_o(cmd_empty), .full_o(cmd_full), .count_o(cmd_count)
  );

  // Core fills the receive queue directly
  i3c_queue #(
    .Width     (CsrDataWidth),
    .QueueDepth(QueueDepth)
  ) u_rx_queue (
    .hclk_i, .arst_n_i,
    .flush_i(rx_flush), .push_i(rx_push_i), .data_i(rx_data_i), .pop_i(rx_pop),
    .data_o(rx_head), .empty_o(rx_empty), .full_o(rx_full_o), .count_o(rx_count)
  );

endmodule

/* tb_i3c_ahb_subsys.sv */
// Testbench for the AHB-Lite I3C register subsystem
// Random AHB and core-side stimulus checked against a register and queue model

module tb_i3c_ahb_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import ahb_pkg::*;
  import i3c_csr_pkg::*;

  localparam int unsigned Seed = 32'h8e56_a836;
  localparam int QueueDepth  = 8;
  localparam int RegRounds   = 40;
  localparam int CmdRounds   = 2;
  localparam int RxRounds    = 2;
  localparam int StatRounds  = 12;
  localparam int FlushRounds = 4;
  // Core-side pushes and pops are budgeted like transfers
  localparam int NumXfers = 8 + 2 * RegRounds + 16 + CmdRounds * (3 * QueueDepth + 6)
                          + RxRounds * (2 * QueueDepth + 4) + StatRounds * (2 * QueueDepth + 8)
                          + FlushRounds * (2 * QueueDepth + 4);
  localparam int MaxCycles = 6 * NumXfers + 200;

  logic        hclk_i;
  logic        arst_n_i;
  logic [31:0] haddr_i;
  logic [2:0]  hburst_i;
  logic [3:0]  hprot_i;
  logic [2:0]  hsize_i;
  logic [1:0]  htrans_i;
  logic [63:0] hwdata_i;
  logic [7:0]  hwstrb_i;
  logic        hwrite_i;
  logic        hsel_i;
  logic        hready_i;
  logic [63:0] hrdata_o;
  logic        hreadyout_o;
  logic        hresp_o;
  logic        cmd_valid_o;
  logic [31:0] cmd_data_o;
  logic        cmd_pop_i;
  logic        rx_push_i;
  logic [31:0] rx_data_i;
  logic        rx_full_o;
  logic        intr_o;

  logic [31:0] hc_model;
  logic [31:0] thld_model;
  logic [31:0] ien_model;
  logic [31:0] cmd_model[$];
  logic [31:0] rx_model[$];
  logic [63:0] last_rdata;
  logic        last_err;
  int          last_cycles;
  int          cycle_cnt = 0;

  i3c_ahb_subsys dut0 (.*);

  always #5 hclk_i = ~hclk_i;

  always @(posedge hclk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: actual 0x%h expected 0x%h", name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Byte strobes of one 32-bit lane expanded to bit enables
  function automatic logic [31:0] lane_biten(input logic lane, input logic [7:0] strb);
    logic [31:0] m;
    int base;
    base = lane ? 4 : 0;
    for (int i = 0; i < 4; i++) begin
      m[i*8 +: 8] = {8{strb[base + i]}};
    end
    return m;
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    int cmd_free;
    cmd_free = QueueDepth - cmd_model.size();
    s = '0;
    s[0] = cmd_free >= int'(thld_model[7:0]);
    s[1] = (rx_model.size() != 0) && (rx_model.size() >= int'(thld_model[15:8]));
    return s;
  endfunction

  function automatic logic expected_intr();
    return |(expected_status() & ien_model);
  endfunction

  function automatic logic [31:0] expected_qsize();
    return {16'h0, 8'(rx_model.size()), 8'(cmd_model.size())};
  endfunction

  function automatic logic [31:0] shadow_of(input logic [4:0] offset);
    case (offset)
      HC_CONTROL:      return hc_model;
      QUEUE_THLD_CTRL: return thld_model;
      default:         return ien_model;
    endcase
  endfunction

  // One single-beat transfer; waits for hreadyout_o and checks the ERROR shape
  task automatic ahb_transfer(input logic [4:0] offset, input logic write, input logic [2:0] size,
                              input logic [63:0] wdata, input logic [7:0] strb);
    logic err_low;
    logic done;
    @(negedge hclk_i);
    haddr_i  = ($urandom & 32'hFFFF_FFE0) | 32'(offset);
    hwrite_i = write;
    hsize_i  = size;
    htrans_i = NONSEQ;
    hsel_i   = 1'b1;
    hburst_i = 3'($urandom);
    hprot_i  = 4'($urandom);
    @(negedge hclk_i);
    hsel_i   = 1'b0;
    htrans_i = IDLE;
    hwdata_i = wdata;
    hwstrb_i = strb;
    err_low  = 1'b0;
    done     = 1'b0;
    last_cycles = 0;
    while (!done) begin
      last_cycles++;
      if (err_low) begin
        check_value("hresp_o", 64'(hresp_o), 64'(ERROR));
        check_value("hreadyout_o", 64'(hreadyout_o), 64'h1);
      end
      if (hreadyout_o) begin
        done       = 1'b1;
        last_rdata = hrdata_o;
        last_err   = (hresp_o == ERROR);
        if (last_err) check_value("hresp_o first ERROR cycle", 64'(err_low), 64'h1);
      end else begin
        err_low = (hresp_o == ERROR);
        @(negedge hclk_i);
      end
    end
  endtask

  task automatic ahb_write(input logic [4:0] offset, input logic [31:0] data,
                           input logic [7:0] strb);
    logic [63:0] wdata;
    // Other lane carries junk that must be ignored
    wdata = {$urandom, $urandom};
    if (offset[2]) wdata[63:32] = data;
    else wdata[31:0] = data;
    ahb_transfer(offset, 1'b1, HsizeWord, wdata, strb);
  endtask

  task automatic ahb_read(input logic [4:0] offset);
    ahb_transfer(offset, 1'b0, HsizeWord, 64'h0, 8'h0);
  endtask

  task automatic read_expect(input logic [4:0] offset, input logic [31:0] expected);
    csr_offset_e reg_name;
    string tag;
    reg_name = csr_offset_e'(offset);
    tag = reg_name.name();
    ahb_read(offset);
    check_value({"hresp_o ", tag}, 64'(last_err), 64'h0);
    check_value({"hrdata_o ", tag}, last_rdata,
                offset[2] ? {expected, 32'h0} : {32'h0, expected});
  endtask

  task automatic expect_error(input string what);
    check_value({"hresp_o ", what}, 64'(last_err), 64'h1);
    check_value({"hrdata_o ", what}, last_rdata, 64'h0);
  endtask

  task automatic write_rw(input logic [4:0] offset, input logic [31:0] data,
                          input logic [7:0] strb);
    logic [31:0] m;
    m = lane_biten(offset[2], strb);
    ahb_write(offset, data, strb);
    check_value("hresp_o write", 64'(last_err), 64'h0);
    case (offset)
      HC_CONTROL:      hc_model = (hc_model & ~m) | (data & m);
      QUEUE_THLD_CTRL: thld_model = (thld_model & ~m) | (data & m);
      default:         ien_model = (ien_model & ~m) | (data & m);
    endcase
  endtask

  task automatic cmd_write(input logic [31:0] data, input logic [7:0] strb);
    ahb_write(COMMAND_PORT, data, strb);
    check_value("hresp_o COMMAND_PORT", 64'(last_err), 64'h0);
    cmd_model.push_back(data & lane_biten(1'b0, strb));
  endtask

  task automatic core_push(input logic [31:0] data);
    @(negedge hclk_i);
    rx_push_i = 1'b1;
    rx_data_i = data;
    @(negedge hclk_i);
    rx_push_i = 1'b0;
    rx_model.push_back(data);
    check_value("rx_full_o", 64'(rx_full_o), 64'(rx_model.size() == QueueDepth));
  endtask

  task automatic core_pop();
    @(negedge hclk_i);
    check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h1);
    check_value("cmd_data_o", 64'(cmd_data_o), 64'(cmd_model[0]));
    cmd_pop_i = 1'b1;
    @(negedge hclk_i);
    cmd_pop_i = 1'b0;
    void'(cmd_model.pop_front());
  endtask

  task automatic flush_queues(input logic [1:0] sel);
    ahb_write(RESET_CONTROL, {30'h0, sel}, 8'hF0);
    check_value("hresp_o RESET_CONTROL", 64'(last_err), 64'h0);
    if (sel[0]) cmd_model.delete();
    if (sel[1]) rx_model.delete();
  endtask

  task automatic test_rw_regs();
    logic [4:0] off;
    int sel;
    read_expect(HC_CONTROL, 32'h0);
    read_expect(QUEUE_THLD_CTRL, 32'h0);
    read_expect(INTR_ENABLE, 32'h0);
    read_expect(RESET_CONTROL, 32'h0);
    read_expect(QUEUE_SIZE, 32'h0);
    read_expect(INTR_STATUS, expected_status());
    for (int i = 0; i < RegRounds; i++) begin
      sel = $urandom_range(0, 2);
      off = (sel == 0) ? HC_CONTROL : ((sel == 1) ? QUEUE_THLD_CTRL : INTR_ENABLE);
      write_rw(off, $urandom, 8'($urandom));
      read_expect(off, shadow_of(off));
    end
  endtask

  // The eight offsets fill the whole block window, so every word address decodes
  task automatic test_errors();
    ahb_write(INTR_STATUS, $urandom, 8'hFF);
    expect_error("write INTR_STATUS");
    ahb_write(QUEUE_SIZE, $urandom, 8'hFF);
    expect_error("write QUEUE_SIZE");
    ahb_write(RX_DATA_PORT, $urandom, 8'hFF);
    expect_error("write RX_DATA_PORT");
    ahb_read(COMMAND_PORT);
    expect_error("read COMMAND_PORT");
    ahb_transfer(HC_CONTROL, 1'b1, 3'b011, {$urandom, $urandom}, 8'hFF);
    expect_error("wide write");
    check_value("data phase cycles", 64'(last_cycles), 64'd3);
    ahb_transfer(INTR_ENABLE, 1'b0, 3'($urandom_range(3, 7)), 64'h0, 8'h0);
    expect_error("wide read");
    check_value("data phase cycles", 64'(last_cycles), 64'd3);
    read_expect(HC_CONTROL, hc_model);
    read_expect(QUEUE_THLD_CTRL, thld_model);
    read_expect(INTR_ENABLE, ien_model);
    read_expect(QUEUE_SIZE, expected_qsize());
  endtask

  task automatic test_cmd_path();
    for (int r = 0; r < CmdRounds; r++) begin
      write_rw(HC_CONTROL, 32'h0, 8'h0F);
      for (int i = 0; i < QueueDepth; i++) begin
        cmd_write($urandom, 8'($urandom));
        check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h0);
        read_expect(QUEUE_SIZE, expected_qsize());
      end
      ahb_write(COMMAND_PORT, $urandom, 8'hFF);
      expect_error("COMMAND_PORT overflow");
      check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h0);
      write_rw(HC_CONTROL, 32'h1, 8'h0F);
      while (cmd_model.size() > 0) core_pop();
      check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h0);
      read_expect(QUEUE_SIZE, expected_qsize());
    end
  endtask

  task automatic test_rx_path();
    for (int r = 0; r < RxRounds; r++) begin
      for (int i = 0; i < QueueDepth; i++) core_push($urandom);
      read_expect(QUEUE_SIZE, expected_qsize());
      while (rx_model.size() > 0) read_expect(RX_DATA_PORT, rx_model.pop_front());
      check_value("rx_full_o", 64'(rx_full_o), 64'h0);
      ahb_read(RX_DATA_PORT);
      expect_error("read empty RX_DATA_PORT");
    end
  endtask

  task automatic test_status_intr();
    logic old_intr;
    int n_cmd;
    int n_rx;
    for (int r = 0; r < StatRounds; r++) begin
      flush_queues(2'b11);
      write_rw(QUEUE_THLD_CTRL, {16'($urandom), 8'($urandom_range(0, QueueDepth + 1)),
                                 8'($urandom_range(0, QueueDepth + 1))}, 8'hFF);
      write_rw(INTR_ENABLE, $urandom, 8'h0F);
      n_cmd = $urandom_range(0, QueueDepth);
      n_rx  = $urandom_range(0, QueueDepth - 1);
      for (int i = 0; i < n_cmd; i++) cmd_write($urandom, 8'h0F);
      for (int i = 0; i < n_rx; i++) core_push($urandom);
      read_expect(INTR_STATUS, expected_status());
      check_value("intr_o", 64'(intr_o), 64'(expected_intr()));
      // Receive threshold one above the fill level so the next push raises intr_o
      write_rw(INTR_ENABLE, 32'h2, 8'h0F);
      write_rw(QUEUE_THLD_CTRL, {16'h0, 8'(n_rx + 1), 8'h0}, 8'h02);
      // intr_o follows the status change one cycle late
      old_intr = expected_intr();
      @(negedge hclk_i);
      rx_push_i = 1'b1;
      rx_data_i = $urandom;
      @(negedge hclk_i);
      rx_push_i = 1'b0;
      rx_model.push_back(rx_data_i);
      check_value("intr_o", 64'(intr_o), 64'(old_intr));
      @(negedge hclk_i);
      check_value("intr_o", 64'(intr_o), 64'(expected_intr()));
    end
  endtask

  task automatic test_flush();
    logic [31:0] data;
    logic [31:0] m;
    logic [7:0]  strb;
    int n_cmd;
    int n_rx;
    for (int r = 0; r < FlushRounds; r++) begin
      flush_queues(2'b11);
      n_cmd = $urandom_range(1, QueueDepth);
      n_rx  = $urandom_range(1, QueueDepth);
      for (int i = 0; i < n_cmd; i++) cmd_write($urandom, 8'h0F);
      for (int i = 0; i < n_rx; i++) core_push($urandom);
      data = $urandom;
      strb = 8'($urandom);
      m = data & lane_biten(1'b1, strb);
      ahb_write(RESET_CONTROL, data, strb);
      check_value("hresp_o RESET_CONTROL", 64'(last_err), 64'h0);
      if (m[0]) cmd_model.delete();
      if (m[1]) rx_model.delete();
      read_expect(QUEUE_SIZE, expected_qsize());
      read_expect(RESET_CONTROL, 32'h0);
      check_value("rx_full_o", 64'(rx_full_o), 64'(rx_model.size() == QueueDepth));
    end
  endtask

  initial begin
    void'($urandom(Seed));
    hclk_i    = 1'b0;
    arst_n_i  = 1'b0;
    haddr_i   = '0;
    hburst_i  = '0;
    hprot_i   = '0;
    hsize_i   = HsizeWord;
    htrans_i  = IDLE;
    hwdata_i  = '0;
    hwstrb_i  = '0;
    hwrite_i  = 1'b0;
    hsel_i    = 1'b0;
    hready_i  = 1'b1;
    cmd_pop_i = 1'b0;
    rx_push_i = 1'b0;
    rx_data_i = '0;
    hc_model   = '0;
    thld_model = '0;
    ien_model  = '0;
    repeat (16) @(negedge hclk_i);
    arst_n_i = 1'b1;
    @(negedge hclk_i);
    check_value("hreadyout_o", 64'(hreadyout_o), 64'h1);
    check_value("hresp_o", 64'(hresp_o), 64'(OKAY));
    check_value("intr_o", 64'(intr_o), 64'h0);
    check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h0);
    check_value("rx_full_o", 64'(rx_full_o), 64'h0);
    test_rw_regs();
    test_errors();
    test_cmd_path();
    test_rx_path();
    test_status_intr();
    test_flush();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* i3c_ahb_subsys.f */
ahb_pkg.sv
i3c_csr_pkg.sv
i3c_queue.sv
ahb_csr_bridge.sv
i3c_csr_regs.sv
i3c_ahb_subsys.sv
tb_i3c_ahb_subsys.sv

/* Makefile */
# Verilator build and run of the I3C AHB-Lite subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_ahb_subsys
FILELIST  ?= i3c_ahb_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
